//--- tb/noc_trace.txt
// Hex fields: en cord1 cord0 dest1 dest0 cycles lb_err, en bit 0 is node 0
// cycles is the enabled run length, lb_err the loopback error flag after the drain
1_2_1_F_F_00C8_0
2_2_1_F_F_00C8_0
3_2_1_F_F_0190_0
3_5_3_F_F_012C_0
1_5_3_F_F_0096_0
2_5_3_F_F_0064_0
// Node 0 aims at a wrong coordinate, the loopback flag stays set after this
3_2_1_F_7_00C8_1
3_2_1_F_F_0064_1
// End of trace
0_0_0_0_0_0000_0

//--- files.f
verilog/noc_test_pkg.sv
verilog/traffic_node.sv
verilog/flit_link_arbiter.sv
verilog/loopback_node.sv
verilog/noc_test_top.sv
tb/tb_noc_checker.sv
tb/tb_noc_test.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the NoC traffic test with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_noc_test -f files.f --Mdir "$BUILD_DIR" -o sim_noc_test
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_noc_test" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
  exit 1
fi
exit 0

//--- tb/tb_noc_test.sv
/*
  NoC traffic test bench
  Clock, reset and trace driven phases around the traffic test top
*/
`timescale 1ns/1ps
`default_nettype none

module tb_noc_test;

  import noc_test_pkg::*;

  localparam int RESET_CYCLES  = 16;
  localparam int TRACE_DEPTH   = 16;
  localparam int DRAIN_QUIET   = 16;
  localparam int DRAIN_TIMEOUT = 2000;

  logic                         mc_clk;
  logic                         mc_reset;
  logic [NUM_NODES-1:0]         node_en;
  cord_t [NUM_NODES-1:0]        node_cord;
  cord_t [NUM_NODES-1:0]        node_dest;
  logic                         phase_start;
  logic                         phase_end;
  logic                         exp_lb_err;
  wire [NUM_NODES-1:0][31:0]    sent;
  wire [NUM_NODES-1:0][31:0]    received;
  wire [NUM_NODES-1:0]          node_error;
  wire                          loopback_error;
  wire [31:0]                   check_errors;
  int                           timeouts;
  int                           phases_run;

  // Fields per line: en, cord1, cord0, dest1, dest0, cycles, lb_err
  logic [39:0] trace_mem [0:TRACE_DEPTH-1];

  always #4 mc_clk = ~mc_clk;

  noc_test_top noc_test_top_i
    (.mc_clk_i         (mc_clk)
    ,.mc_reset_i       (mc_reset)
    ,.node_en_i        (node_en)
    ,.node_cord_i      (node_cord)
    ,.node_dest_i      (node_dest)
    ,.sent_o           (sent)
    ,.received_o       (received)
    ,.node_error_o     (node_error)
    ,.loopback_error_o (loopback_error)
    );

  tb_noc_checker monitor
    (.mc_clk_i         (mc_clk)
    ,.mc_reset_i       (mc_reset)
    ,.en_i             (node_en)
    ,.sent_i           (sent)
    ,.received_i       (received)
    ,.node_error_i     (node_error)
    ,.loopback_error_i (loopback_error)
    ,.phase_start_i    (phase_start)
    ,.phase_end_i      (phase_end)
    ,.exp_lb_err_i     (exp_lb_err)
    ,.error_count_o    (check_errors)
    );

  // Both links are idle once every node got back all it sent
  task automatic wait_for_drain();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < DRAIN_QUIET && waited < DRAIN_TIMEOUT)
    begin
      @(posedge mc_clk);
      #1;
      waited++;
      if (sent == received)
        quiet++;
      else
        quiet = 0;
    end
    if (quiet < DRAIN_QUIET)
    begin
      $display("Timeout at %0t: returned packets did not catch up within %0d cycles",
               $time, DRAIN_TIMEOUT);
      timeouts++;
    end
  endtask

  task automatic run_phase(input logic [39:0] entry);
    int run_cycles;
    run_cycles = int'(entry[19:4]);
    @(posedge mc_clk);
    #1;
    node_en      = entry[36 +: NUM_NODES];
    node_cord[1] = entry[35:32];
    node_cord[0] = entry[31:28];
    node_dest[1] = entry[27:24];
    node_dest[0] = entry[23:20];
    exp_lb_err   = entry[0];
    phase_start  = 1'b1;
    @(posedge mc_clk);
    #1;
    phase_start = 1'b0;
    repeat (run_cycles) @(posedge mc_clk);
    #1;
    node_en = '0;
    wait_for_drain();
    phase_end = 1'b1;
    @(posedge mc_clk);
    #1;
    phase_end = 1'b0;
  endtask

  initial
  begin
    mc_clk      = 1'b0;
    mc_reset    = 1'b1;
    node_en     = '0;
    node_cord   = '0;
    node_dest   = '0;
    phase_start = 1'b0;
    phase_end   = 1'b0;
    exp_lb_err  = 1'b0;
    timeouts    = 0;
    phases_run  = 0;
    $readmemh("tb/noc_trace.txt", trace_mem);
    repeat (RESET_CYCLES) @(posedge mc_clk);
    #1;
    mc_reset = 1'b0;
    for (int idx = 0; idx < TRACE_DEPTH; idx++)
    begin
      // A zero run length marks the end of the trace
      if ($isunknown(trace_mem[idx]) || trace_mem[idx][19:4] == 16'h0)
        break;
      run_phase(trace_mem[idx]);
      phases_run++;
      if (timeouts != 0)
        break;
    end
    @(posedge mc_clk);
    #1;
    if (phases_run == 0)
      $display("No phases were found in tb/noc_trace.txt");
    $display("Error counts: %0d check errors, %0d timeouts, %0d phases run",
             check_errors, timeouts, phases_run);
    if (check_errors == 0 && timeouts == 0 && phases_run != 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_noc_checker.sv
/*
  NoC traffic test checker
  Compares DUT counts and error flags with the trace expectations
*/
`timescale 1ns/1ps
`default_nettype none

module tb_noc_checker
  (input  wire logic                                     mc_clk_i
  ,input  wire logic                                     mc_reset_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0]       en_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0][31:0] sent_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0][31:0] received_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0]       node_error_i
  ,input  wire logic                                     loopback_error_i
  ,input  wire logic                                     phase_start_i
  ,input  wire logic                                     phase_end_i
  ,input  wire logic                                     exp_lb_err_i
  ,output logic [31:0]                                   error_count_o
  );

  import noc_test_pkg::*;

  int                         errors = 0;
  logic                       leaving_reset = 1'b0;
  logic [NUM_NODES-1:0]       phase_en = '0;
  logic [NUM_NODES-1:0]       node_err_seen = '0;
  logic [NUM_NODES-1:0][31:0] base_sent = '0;
  logic [NUM_NODES-1:0][31:0] base_recv = '0;

  assign error_count_o = 32'(errors);

  task automatic flag_error(input string msg);
    errors++;
    $display("ERROR %0t: %s", $time, msg);
  endtask

  task automatic check_reset_state();
    if (sent_i != '0 || received_i != '0)
      flag_error("packet counts are not zero after reset");
    if (node_error_i != '0 || loopback_error_i)
      flag_error("error outputs are not low after reset");
  endtask

  // Per-packet round-robin keeps the two senders within one packet
  task automatic check_balance();
    int delta;
    delta = int'(sent_i[0] - base_sent[0]) - int'(sent_i[1] - base_sent[1]);
    if (delta > 1 || delta < -1)
      flag_error($sformatf("sent counts %0d apart with both nodes enabled", delta));
  endtask

  task automatic check_phase_end();
    for (int k = 0; k < NUM_NODES; k++)
    begin
      if (received_i[k] != sent_i[k])
        flag_error($sformatf("node %0d received %0d packets, expected %0d",
                             k, received_i[k], sent_i[k]));
      if (phase_en[k] && sent_i[k] == base_sent[k])
        flag_error($sformatf("node %0d sent no packet while enabled", k));
      if (!phase_en[k] && (sent_i[k] != base_sent[k] || received_i[k] != base_recv[k]))
        flag_error($sformatf("node %0d counts changed while disabled", k));
    end
    if (loopback_error_i != exp_lb_err_i)
      flag_error($sformatf("loopback error is %0b, expected %0b",
                           loopback_error_i, exp_lb_err_i));
  endtask

  // Mid-cycle sampling, away from both clock edges
  always @(negedge mc_clk_i)
  begin
    if (mc_reset_i)
      leaving_reset = 1'b1;
    else
    begin
      if (leaving_reset)
        check_reset_state();
      leaving_reset = 1'b0;
      for (int k = 0; k < NUM_NODES; k++)
      begin
        if (node_error_i[k] && !node_err_seen[k])
        begin
          node_err_seen[k] = 1'b1;
          flag_error($sformatf("node %0d flagged a returned data mismatch", k));
        end
      end
      if (phase_start_i)
      begin
        phase_en  = en_i;
        base_sent = sent_i;
        base_recv = received_i;
      end
      if (&en_i)
        check_balance();
      if (phase_end_i)
        check_phase_end();
    end
  end

endmodule

`default_nettype wire

//--- verilog/noc_test_top.sv
/*
  NoC traffic test top
  Two traffic nodes share one link pair to a loopback node
*/
`timescale 1ns/1ps
`default_nettype none

module noc_test_top
  (input  wire logic                                                mc_clk_i
  ,input  wire logic                                                mc_reset_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0]                  node_en_i
  ,input  wire noc_test_pkg::cord_t [noc_test_pkg::NUM_NODES-1:0]   node_cord_i
  ,input  wire noc_test_pkg::cord_t [noc_test_pkg::NUM_NODES-1:0]   node_dest_i
  ,output wire logic [noc_test_pkg::NUM_NODES-1:0][31:0]            sent_o
  ,output wire logic [noc_test_pkg::NUM_NODES-1:0][31:0]            received_o
  ,output wire logic [noc_test_pkg::NUM_NODES-1:0]                  node_error_o
  ,output wire logic                                                loopback_error_o
  );

  import noc_test_pkg::*;

  wire [NUM_NODES-1:0]        fwd_v;
  wire flit_t [NUM_NODES-1:0] fwd_data;
  wire [NUM_NODES-1:0]        fwd_ready;
  wire [NUM_NODES-1:0]        rev_v;
  wire flit_t [NUM_NODES-1:0] rev_data;

  wire        link_fwd_v;
  wire flit_t link_fwd_data;
  wire        link_fwd_ready;
  wire        link_rev_v;
  wire flit_t link_rev_data;
  wire        link_rev_ready;

  for (genvar i = 0; i < NUM_NODES; i++)
  begin : g_node
    traffic_node node
      (.mc_clk_i    (mc_clk_i)
      ,.mc_reset_i  (mc_reset_i)
      ,.mc_en_i     (node_en_i[i])
      ,.my_cord_i   (node_cord_i[i])
      ,.dest_cord_i (node_dest_i[i])
      ,.fwd_v_o     (fwd_v[i])
      ,.fwd_data_o  (fwd_data[i])
      ,.fwd_ready_i (fwd_ready[i])
      ,.rev_v_i     (rev_v[i])
      ,.rev_data_i  (rev_data[i])
      ,.sent_o      (sent_o[i])
      ,.received_o  (received_o[i])
      ,.error_o     (node_error_o[i])
      );
  end

  flit_link_arbiter arbiter
    (.mc_clk_i         (mc_clk_i)
    ,.mc_reset_i       (mc_reset_i)
    ,.fwd_v_i          (fwd_v)
    ,.fwd_data_i       (fwd_data)
    ,.fwd_ready_o      (fwd_ready)
    ,.link_fwd_v_o     (link_fwd_v)
    ,.link_fwd_data_o  (link_fwd_data)
    ,.link_fwd_ready_i (link_fwd_ready)
    ,.link_rev_v_i     (link_rev_v)
    ,.link_rev_data_i  (link_rev_data)
    ,.link_rev_ready_o (link_rev_ready)
    ,.node_cord_i      (node_cord_i)
    ,.rev_v_o          (rev_v)
    ,.rev_data_o       (rev_data)
    );

  loopback_node loopback
    (.mc_clk_i     (mc_clk_i)
    ,.mc_reset_i   (mc_reset_i)
    ,.my_cord_i    (LOOPBACK_CORD)
    ,.req_v_i      (link_fwd_v)
    ,.req_data_i   (link_fwd_data)
    ,.req_ready_o  (link_fwd_ready)
    ,.resp_v_o     (link_rev_v)
    ,.resp_data_o  (link_rev_data)
    ,.resp_ready_i (link_rev_ready)
    ,.error_o      (loopback_error_o)
    );

endmodule

`default_nettype wire

//--- verilog/loopback_node.sv
/*
  Loopback node
  Collects each request packet and returns its payload to the source
*/
`timescale 1ns/1ps
`default_nettype none

module loopback_node
  (input  wire logic                 mc_clk_i
  ,input  wire logic                 mc_reset_i
  ,input  wire noc_test_pkg::cord_t  my_cord_i
  ,input  wire logic                 req_v_i
  ,input  wire noc_test_pkg::flit_t  req_data_i
  ,output logic                      req_ready_o
  ,output logic                      resp_v_o
  ,output noc_test_pkg::flit_t       resp_data_o
  ,input  wire logic                 resp_ready_i
  ,output logic                      error_o
  );

  import noc_test_pkg::*;

  typedef enum logic {LB_COLLECT, LB_RESPOND} lb_state_e;

  lb_state_e state_r;
  len_t      flit_cnt_r;
  cord_t     src_cord_r;
  payload_t  payload_r;
  flit_t     resp_hdr;
  logic      req_xfer;
  logic      resp_xfer;
  logic      flit_last;

  assign req_ready_o = (state_r == LB_COLLECT);
  assign resp_v_o    = (state_r == LB_RESPOND);
  assign req_xfer    = req_v_i & req_ready_o;
  assign resp_xfer   = resp_v_o & resp_ready_i;
  assign flit_last   = (flit_cnt_r == len_t'(PACKET_FLITS-1));

  always_comb
  begin
    resp_hdr = '0;
    resp_hdr[HDR_DEST_LSB +: $bits(cord_t)] = src_cord_r;
    resp_hdr[HDR_SRC_LSB +: $bits(cord_t)]  = my_cord_i;
    resp_hdr[HDR_LEN_LSB +: $bits(len_t)]   = len_t'(PAYLOAD_FLITS);
  end

  always_comb
  begin
    case (flit_cnt_r)
      2'd0:    resp_data_o = resp_hdr;
      2'd1:    resp_data_o = payload_r[0 +: $bits(flit_t)];
      default: resp_data_o = payload_r[$bits(flit_t) +: $bits(flit_t)];
    endcase
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      state_r    <= LB_COLLECT;
      flit_cnt_r <= '0;
      error_o    <= 1'b0;
    end
    else
    begin
      if (req_xfer && flit_cnt_r == '0 &&
          req_data_i[HDR_DEST_LSB +: $bits(cord_t)] != my_cord_i)
        error_o <= 1'b1;
      if (req_xfer || resp_xfer)
      begin
        flit_cnt_r <= flit_last ? '0 : flit_cnt_r + 1'b1;
        if (flit_last)
          state_r <= (state_r == LB_COLLECT) ? LB_RESPOND : LB_COLLECT;
      end
    end
  end

  // Source coordinate from the header and both payload halves
  always_ff @(posedge mc_clk_i)
  begin
    if (req_xfer)
    begin
      case (flit_cnt_r)
        2'd0:    src_cord_r <= req_data_i[HDR_SRC_LSB +: $bits(cord_t)];
        2'd1:    payload_r[0 +: $bits(flit_t)] <= req_data_i;
        default: payload_r[$bits(flit_t) +: $bits(flit_t)] <= req_data_i;
      endcase
    end
  end

  // Request ends where the collector turns to respond
  a_no_req_in_resp: assert property (@(posedge mc_clk_i) disable iff (mc_reset_i)
    req_xfer && flit_cnt_r == '0 |->
      req_data_i[HDR_LEN_LSB +: $bits(len_t)] == len_t'(PAYLOAD_FLITS));

endmodule

`default_nettype wire

//--- verilog/flit_link_arbiter.sv
/*
  Flit link arbiter
  Round-robin wormhole grant of the shared forward link and
  coordinate steering of the shared reverse link
*/
`timescale 1ns/1ps
`default_nettype none

module flit_link_arbiter
  (input  wire logic                                                mc_clk_i
  ,input  wire logic                                                mc_reset_i
  ,input  wire logic [noc_test_pkg::NUM_NODES-1:0]                  fwd_v_i
  ,input  wire noc_test_pkg::flit_t [noc_test_pkg::NUM_NODES-1:0]   fwd_data_i
  ,output logic [noc_test_pkg::NUM_NODES-1:0]                       fwd_ready_o
  ,output logic                                                     link_fwd_v_o
  ,output noc_test_pkg::flit_t                                      link_fwd_data_o
  ,input  wire logic                                                link_fwd_ready_i
  ,input  wire logic                                                link_rev_v_i
  ,input  wire noc_test_pkg::flit_t                                 link_rev_data_i
  ,output logic                                                     link_rev_ready_o
  ,input  wire noc_test_pkg::cord_t [noc_test_pkg::NUM_NODES-1:0]   node_cord_i
  ,output logic [noc_test_pkg::NUM_NODES-1:0]                       rev_v_o
  ,output noc_test_pkg::flit_t [noc_test_pkg::NUM_NODES-1:0]        rev_data_o
  );

  import noc_test_pkg::*;

  node_idx_t rr_ptr_r;
  node_idx_t grant_r;
  node_idx_t pick;
  node_idx_t cur_grant;
  len_t      fwd_cnt_r;
  logic      fwd_locked;
  logic      fwd_xfer;

  node_idx_t rev_sel_r;
  node_idx_t rev_hdr_sel;
  node_idx_t rev_sel;
  len_t      rev_cnt_r;
  logic      rev_xfer;

  // First requester at or after the pointer
  always_comb
  begin
    pick = rr_ptr_r;
    for (int k = NUM_NODES-1; k >= 0; k--)
    begin
      if (fwd_v_i[(int'(rr_ptr_r) + k) % NUM_NODES])
        pick = node_idx_t'((int'(rr_ptr_r) + k) % NUM_NODES);
    end
  end

  assign fwd_locked      = (fwd_cnt_r != '0);
  assign cur_grant       = fwd_locked ? grant_r : pick;
  assign link_fwd_v_o    = fwd_v_i[cur_grant];
  assign link_fwd_data_o = fwd_data_i[cur_grant];
  assign fwd_xfer        = link_fwd_v_o & link_fwd_ready_i;

  always_comb
  begin
    fwd_ready_o = '0;
    fwd_ready_o[cur_grant] = link_fwd_ready_i;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      rr_ptr_r  <= '0;
      grant_r   <= '0;
      fwd_cnt_r <= '0;
    end
    else if (fwd_xfer)
    begin
      if (fwd_locked)
        fwd_cnt_r <= fwd_cnt_r - 1'b1;
      else
      begin
        // Header flit locks the grant until the tail
        fwd_cnt_r <= link_fwd_data_o[HDR_LEN_LSB +: $bits(len_t)];
        grant_r   <= pick;
        rr_ptr_r  <= node_idx_t'((int'(pick) + 1) % NUM_NODES);
      end
    end
  end

  always_comb
  begin
    rev_hdr_sel = '0;
    for (int k = 0; k < NUM_NODES; k++)
    begin
      if (node_cord_i[k] == link_rev_data_i[HDR_DEST_LSB +: $bits(cord_t)])
        rev_hdr_sel = node_idx_t'(k);
    end
  end

  // Nodes always sink returned flits
  assign link_rev_ready_o = 1'b1;
  assign rev_xfer         = link_rev_v_i & link_rev_ready_o;
  assign rev_sel          = (rev_cnt_r == '0) ? rev_hdr_sel : rev_sel_r;

  always_comb
  begin
    rev_v_o = '0;
    rev_v_o[rev_sel] = link_rev_v_i;
    for (int k = 0; k < NUM_NODES; k++)
      rev_data_o[k] = link_rev_data_i;
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      rev_cnt_r <= '0;
      rev_sel_r <= '0;
    end
    else if (rev_xfer)
    begin
      if (rev_cnt_r == '0)
      begin
        rev_cnt_r <= link_rev_data_i[HDR_LEN_LSB +: $bits(len_t)];
        rev_sel_r <= rev_hdr_sel;
      end
      else
        rev_cnt_r <= rev_cnt_r - 1'b1;
    end
  end

  // Locked grant keeps the same node and that node keeps its packet going
  a_grant_hold: assert property (@(posedge mc_clk_i) disable iff (mc_reset_i)
    fwd_cnt_r != '0 |-> $stable(cur_grant) && link_fwd_v_o);

endmodule

`default_nettype wire

//--- verilog/traffic_node.sv
/*
  Traffic node
  Sends numbered data packets on the forward link and checks the
  payload that comes back on the reverse link
*/
`timescale 1ns/1ps
`default_nettype none

module traffic_node
  (input  wire logic                 mc_clk_i
  ,input  wire logic                 mc_reset_i
  ,input  wire logic                 mc_en_i
  ,input  wire noc_test_pkg::cord_t  my_cord_i
  ,input  wire noc_test_pkg::cord_t  dest_cord_i
  ,output logic                      fwd_v_o
  ,output noc_test_pkg::flit_t       fwd_data_o
  ,input  wire logic                 fwd_ready_i
  ,input  wire logic                 rev_v_i
  ,input  wire noc_test_pkg::flit_t  rev_data_i
  ,output logic [31:0]               sent_o
  ,output logic [31:0]               received_o
  ,output logic                      error_o
  );

  import noc_test_pkg::*;

  typedef enum logic [1:0] {SEND_IDLE, SEND_HEADER, SEND_PAYLOAD} send_state_e;
  typedef enum logic {RECV_HEADER, RECV_PAYLOAD} recv_state_e;

  send_state_e send_state_r;
  logic        send_half_r;
  payload_t    send_gen_r;
  flit_t       send_hdr;
  logic        fwd_xfer;
  logic        send_last;

  recv_state_e recv_state_r;
  logic        recv_half_r;
  logic        recv_done_r;
  cord_t       recv_dest_r;
  payload_t    recv_data_r;
  payload_t    check_gen_r;
  logic        mismatch;

  always_comb
  begin
    send_hdr = '0;
    send_hdr[HDR_DEST_LSB +: $bits(cord_t)] = dest_cord_i;
    send_hdr[HDR_SRC_LSB +: $bits(cord_t)]  = my_cord_i;
    send_hdr[HDR_LEN_LSB +: $bits(len_t)]   = len_t'(PAYLOAD_FLITS);
  end

  assign fwd_v_o   = (send_state_r != SEND_IDLE);
  assign fwd_xfer  = fwd_v_o & fwd_ready_i;
  assign send_last = fwd_xfer & (send_state_r == SEND_PAYLOAD) & send_half_r;

  // Low half first, then high half
  always_comb
  begin
    if (send_state_r != SEND_PAYLOAD)
      fwd_data_o = send_hdr;
    else if (send_half_r)
      fwd_data_o = send_gen_r[$bits(flit_t) +: $bits(flit_t)];
    else
      fwd_data_o = send_gen_r[0 +: $bits(flit_t)];
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      send_state_r <= SEND_IDLE;
      send_half_r  <= 1'b0;
      send_gen_r   <= '0;
      sent_o       <= '0;
    end
    else
    begin
      case (send_state_r)
        SEND_IDLE:
          if (mc_en_i)
            send_state_r <= SEND_HEADER;
        SEND_HEADER:
          if (fwd_xfer)
            send_state_r <= SEND_PAYLOAD;
        default:
          if (fwd_xfer)
          begin
            send_half_r <= ~send_half_r;
            // Back to back packets while enabled
            if (send_half_r)
              send_state_r <= mc_en_i ? SEND_HEADER : SEND_IDLE;
          end
      endcase
      if (send_last)
      begin
        send_gen_r <= send_gen_r + 1'b1;
        sent_o     <= sent_o + 1'b1;
      end
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      recv_state_r <= RECV_HEADER;
      recv_half_r  <= 1'b0;
      recv_done_r  <= 1'b0;
    end
    else
    begin
      recv_done_r <= 1'b0;
      if (rev_v_i)
      begin
        if (recv_state_r == RECV_HEADER)
          recv_state_r <= RECV_PAYLOAD;
        else
        begin
          recv_half_r <= ~recv_half_r;
          if (recv_half_r)
          begin
            recv_state_r <= RECV_HEADER;
            recv_done_r  <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge mc_clk_i)
  begin
    if (rev_v_i)
    begin
      if (recv_state_r == RECV_HEADER)
        recv_dest_r <= rev_data_i[HDR_DEST_LSB +: $bits(cord_t)];
      else if (recv_half_r)
        recv_data_r[$bits(flit_t) +: $bits(flit_t)] <= rev_data_i;
      else
        recv_data_r[0 +: $bits(flit_t)] <= rev_data_i;
    end
  end

  assign mismatch = (recv_data_r != check_gen_r) | (recv_dest_r != my_cord_i);

  // Check one cycle after the tail flit
  always_ff @(posedge mc_clk_i)
  begin
    if (mc_reset_i)
    begin
      check_gen_r <= '0;
      received_o  <= '0;
      error_o     <= 1'b0;
    end
    else if (recv_done_r)
    begin
      check_gen_r <= check_gen_r + 1'b1;
      received_o  <= received_o + 1'b1;
      if (mismatch)
        error_o <= 1'b1;
    end
  end

  a_fwd_hold: assert property (@(posedge mc_clk_i) disable iff (mc_reset_i)
    fwd_v_o && !fwd_ready_i |=> fwd_v_o && $stable(fwd_data_o));

endmodule

`default_nettype wire

//--- verilog/noc_test_pkg.sv
/*
  NoC traffic test definitions
  Flit, coordinate and payload types, packet sizes and node indices
*/
`default_nettype none

package noc_test_pkg;

  // Link and header field widths
  typedef logic [15:0] flit_t;
  typedef logic [3:0]  cord_t;
  typedef logic [1:0]  len_t;
  typedef logic [31:0] payload_t;

  // Header flit, then payload flits
  localparam int PAYLOAD_FLITS = 2;
  localparam int PACKET_FLITS  = 3;

  // Header layout, upper bits are zero
  localparam int HDR_DEST_LSB = 0;
  localparam int HDR_SRC_LSB  = 4;
  localparam int HDR_LEN_LSB  = 8;

  localparam int NUM_NODES = 2;

  typedef logic [$clog2(NUM_NODES)-1:0] node_idx_t;

  localparam cord_t LOOPBACK_CORD = 4'hF;

endpackage

`default_nettype wire
